// File: Bender.yml
package:
  name: io_subsys

sources:
  - hw/io_pkg.sv
  - hw/io_bus_decode.sv
  - hw/ms_timer.sv
  - hw/cmd_channel.sv
  - hw/io_status_mux.sv
  - hw/io_subsys_top.sv
  - target: test
    files:
      - dv/tb_clock.sv
      - dv/tb_io_subsys.sv

// File: build.f
hw/io_pkg.sv
hw/io_bus_decode.sv
hw/ms_timer.sv
hw/cmd_channel.sv
hw/io_status_mux.sv
hw/io_subsys_top.sv
dv/tb_clock.sv
dv/tb_io_subsys.sv

// File: dv/tb_io_subsys.sv
// ====================
// tb_io_subsys
// I/O subsystem testbench with reference model and assertions
// ====================

`timescale 1ns/1ps

module tb_io_subsys;

    localparam int TICKS      = 50;
    localparam int N_RAND_WR  = 1000;
    localparam int MAX_CYCLES = 4000;  // about twice the whole sequence

    logic                                   clk_cpu;
    logic                                   rst_n;
    io_pkg::io_req_t                        req;
    logic                                   bus_ready;
    logic [io_pkg::DATA_W-1:0]              rdata;
    logic                                   rvalid;
    logic [7:0]                             led;
    logic [io_pkg::NUM_CH-1:0]              cmd_valid;
    io_pkg::cmd_word_t [io_pkg::NUM_CH-1:0] cmd_data;
    logic [io_pkg::NUM_CH-1:0]              cmd_ready;

    // reference model
    io_pkg::cmd_word_t         model_q [io_pkg::NUM_CH][$];
    int                        model_cnt [io_pkg::NUM_CH];
    logic [7:0]                model_led;
    io_pkg::cmd_word_t         exp_head [io_pkg::NUM_CH];
    logic [io_pkg::NUM_CH-1:0] exp_nonempty;
    logic                      exp_ready;
    logic                      rd_exp_valid;
    logic                      rd_exact;     // counter reads go by delta
    logic                      rd_ms_delta;
    logic [io_pkg::DATA_W-1:0] exp_rdata;

    int                        seed = 11;
    int                        cycle_cnt = 0;
    logic                      ready_rand;
    logic                      ms_check;
    logic [io_pkg::DATA_W-1:0] ms_ref;

    tb_clock i_clk (
        .clk_cpu (clk_cpu),
        .rst_n   (rst_n)
    );

    io_subsys_top #(
        .TICKS_PER_MS (TICKS)
    ) i_dut (
        .clk_cpu     (clk_cpu),
        .rst_n       (rst_n),
        .req_i       (req),
        .bus_ready_o (bus_ready),
        .rdata_o     (rdata),
        .rvalid_o    (rvalid),
        .led_o       (led),
        .cmd_valid_o (cmd_valid),
        .cmd_data_o  (cmd_data),
        .cmd_ready_i (cmd_ready)
    );

    task automatic report_fail();
        $display(">>> FAIL");
        $fatal(1, "stopped at cycle %0d", cycle_cnt);
    endtask

    always @(posedge clk_cpu) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == MAX_CYCLES) begin
            $display("timeout: test sequence did not finish in %0d cycles", MAX_CYCLES);
            report_fail();
        end
    end

    // only a write into a full channel stalls
    always_comb begin
        exp_ready = 1'b1;
        for (int k = 0; k < io_pkg::NUM_CH; k++) begin
            if (req.sel && req.we && (req.addr == io_pkg::ADR_CH_BASE + k)
                    && (model_cnt[k] == io_pkg::CH_DEPTH)) begin
                exp_ready = 1'b0;
            end
        end
    end

    always @(posedge clk_cpu) begin : model_update
        int                        ch;
        logic                      acc;
        logic [io_pkg::DATA_W-1:0] status;
        if (!rst_n) begin
            for (int k = 0; k < io_pkg::NUM_CH; k++) begin
                model_q[k].delete();
            end
            model_led    = '0;
            rd_exp_valid = 1'b0;
            rd_exact     = 1'b0;
            rd_ms_delta  = 1'b0;
            exp_rdata    = '0;
        end else begin
            ch = int'(req.addr) - int'(io_pkg::ADR_CH_BASE);
            if (ch >= io_pkg::NUM_CH) begin
                ch = -1;
            end
            acc = req.sel && exp_ready;
            // read value from the state before this edge
            status = '0;
            for (int k = 0; k < io_pkg::NUM_CH; k++) begin
                status[k]     = (model_cnt[k] != 0);
                status[8 + k] = (model_cnt[k] == io_pkg::CH_DEPTH);
            end
            rd_exp_valid = acc && !req.we;
            rd_exact     = (req.addr != io_pkg::ADR_MS);
            rd_ms_delta  = rd_exp_valid && !rd_exact && ms_check;
            exp_rdata    = '0;
            if (req.addr == io_pkg::ADR_LED) begin
                exp_rdata = {24'd0, model_led};
            end else if (req.addr == io_pkg::ADR_STATUS) begin
                exp_rdata = status;
            end else if (ch >= 0) begin
                exp_rdata = io_pkg::DATA_W'(model_cnt[ch]);
            end
            for (int k = 0; k < io_pkg::NUM_CH; k++) begin
                if ((model_q[k].size() != 0) && cmd_ready[k]) begin
                    void'(model_q[k].pop_front());  // head leaves first
                end
            end
            if (acc && req.we) begin
                if (ch >= 0) begin
                    model_q[ch].push_back(req.wdata);
                end else if (req.addr == io_pkg::ADR_LED) begin
                    model_led = req.wdata[7:0];
                end
            end
        end
        for (int k = 0; k < io_pkg::NUM_CH; k++) begin
            model_cnt[k]    = model_q[k].size();
            exp_nonempty[k] = (model_cnt[k] != 0);
            exp_head[k]     = (model_cnt[k] != 0) ? model_q[k][0] : '0;
        end
    end

    a_ready: assert property (@(posedge clk_cpu) disable iff (!rst_n)
        bus_ready == exp_ready
    ) else begin
        $display("** Error: bus_ready_o = %h, expected %h", $sampled(bus_ready),
                 $sampled(exp_ready));
        report_fail();
    end

    a_rvalid: assert property (@(posedge clk_cpu) disable iff (!rst_n)
        rvalid == rd_exp_valid
    ) else begin
        $display("** Error: rvalid_o = %h, expected %h", $sampled(rvalid),
                 $sampled(rd_exp_valid));
        report_fail();
    end

    a_rdata: assert property (@(posedge clk_cpu) disable iff (!rst_n)
        (rd_exp_valid && rd_exact) |-> (rdata == exp_rdata)
    ) else begin
        $display("** Error: rdata_o = %h, expected %h", $sampled(rdata), $sampled(exp_rdata));
        report_fail();
    end

    // 500 cycles at 50 ticks per ms
    a_ms_delta: assert property (@(posedge clk_cpu) disable iff (!rst_n)
        rd_ms_delta |-> ((rdata - ms_ref >= 32'd9) && (rdata - ms_ref <= 32'd11))
    ) else begin
        $display("** Error: rdata_o = %h, expected %h plus 9 to 11", $sampled(rdata),
                 $sampled(ms_ref));
        report_fail();
    end

    a_led: assert property (@(posedge clk_cpu) disable iff (!rst_n)
        led == model_led
    ) else begin
        $display("** Error: led_o = %h, expected %h", $sampled(led), $sampled(model_led));
        report_fail();
    end

    for (genvar k = 0; k < io_pkg::NUM_CH; k++) begin : g_ch_chk
        a_valid: assert property (@(posedge clk_cpu) disable iff (!rst_n)
            cmd_valid[k] == exp_nonempty[k]
        ) else begin
            $display("** Error: cmd_valid_o[%0d] = %h, expected %h", k,
                     $sampled(cmd_valid[k]), $sampled(exp_nonempty[k]));
            report_fail();
        end

        a_pop: assert property (@(posedge clk_cpu) disable iff (!rst_n)
            (cmd_valid[k] && cmd_ready[k]) |-> (cmd_data[k] == exp_head[k])
        ) else begin
            $display("** Error: cmd_data_o[%0d] = %h, expected %h", k,
                     $sampled(cmd_data[k]), $sampled(exp_head[k]));
            report_fail();
        end

        a_hold: assert property (@(posedge clk_cpu) disable iff (!rst_n)
            (cmd_valid[k] && !cmd_ready[k]) |=> (cmd_valid[k] && $stable(cmd_data[k]))
        ) else begin
            $display("** Error: cmd_data_o[%0d] = %h, expected %h while stalled", k,
                     $sampled(cmd_data[k]), $past(cmd_data[k]));
            report_fail();
        end
    end

    function automatic int model_total();
        int sum;
        sum = 0;
        for (int k = 0; k < io_pkg::NUM_CH; k++) begin
            sum += model_cnt[k];
        end
        return sum;
    endfunction

    task automatic next_cycle();
        logic [31:0] rnd;
        @(negedge clk_cpu);
        if (ready_rand) begin
            rnd       = $random(seed);
            cmd_ready = rnd[io_pkg::NUM_CH-1:0];
        end
    endtask

    // called right after a request is driven on the falling edge
    task automatic wait_accept();
        logic rdy;
        rdy = 1'b0;
        while (!rdy) begin
            #1;
            rdy = bus_ready;  // stable until the next rising edge
            if (!rdy) begin
                next_cycle();
            end
        end
    endtask

    task automatic bus_write(input logic [io_pkg::ADDR_W-1:0] addr,
                             input logic [io_pkg::DATA_W-1:0] data);
        next_cycle();
        req.sel   = 1'b1;
        req.we    = 1'b1;
        req.addr  = addr;
        req.wdata = data;
        wait_accept();
    endtask

    task automatic bus_read(input logic [io_pkg::ADDR_W-1:0] addr);
        next_cycle();
        req.sel   = 1'b1;
        req.we    = 1'b0;
        req.addr  = addr;
        req.wdata = '0;
        wait_accept();
    endtask

    task automatic bus_idle();
        next_cycle();
        req.sel = 1'b0;
        req.we  = 1'b0;
    endtask

    task automatic wait_drained();
        while (model_total() != 0) begin
            next_cycle();
        end
    endtask

    initial begin : stimulus
        int          ch;
        logic [31:0] rnd;
        req        = '0;
        cmd_ready  = '0;
        ready_rand = 1'b0;
        ms_check   = 1'b0;
        ms_ref     = '0;
        wait (rst_n === 1'b1);
        repeat (2) next_cycle();  // reset values seen by the assertions

        // LED register, ignored status write
        bus_write(io_pkg::ADR_LED, 32'hC0DE_F05A);
        bus_read(io_pkg::ADR_LED);
        bus_write(io_pkg::ADR_STATUS, 32'hFFFF_FFFF);
        bus_read(io_pkg::ADR_STATUS);
        rnd = $random(seed);
        bus_write(io_pkg::ADR_LED, rnd);
        bus_read(io_pkg::ADR_LED);

        // random words into random channels
        ready_rand = 1'b1;
        for (int i = 0; i < N_RAND_WR; i++) begin
            rnd = $random(seed);
            ch  = int'(rnd[7:0]) % io_pkg::NUM_CH;
            rnd = $random(seed);
            bus_write(io_pkg::ADR_CH_BASE + ch[io_pkg::ADDR_W-1:0], rnd);
        end
        bus_idle();
        ready_rand = 1'b0;
        cmd_ready  = '1;
        wait_drained();

        // fill channel 2 with its sink stalled
        bus_idle();
        cmd_ready = '0;
        for (int i = 0; i < io_pkg::CH_DEPTH; i++) begin
            rnd = $random(seed);
            bus_write(io_pkg::ADR_CH_BASE + 4'd2, rnd);
        end
        bus_read(io_pkg::ADR_CH_BASE + 4'd2);
        bus_read(io_pkg::ADR_STATUS);
        rnd = $random(seed);
        next_cycle();
        req.sel   = 1'b1;
        req.we    = 1'b1;
        req.addr  = io_pkg::ADR_CH_BASE + 4'd2;
        req.wdata = rnd;  // ninth write hits the full channel
        repeat (3) next_cycle();  // held write
        cmd_ready[2] = 1'b1;
        wait_accept();
        bus_idle();
        cmd_ready = '1;
        wait_drained();

        // timer and unmapped reads
        bus_read(io_pkg::ADR_MS);
        next_cycle();
        req.sel = 1'b0;
        ms_ref  = rdata;
        repeat (500) next_cycle();
        ms_check = 1'b1;
        bus_read(io_pkg::ADR_MS);
        next_cycle();
        req.sel  = 1'b0;
        ms_check = 1'b0;
        bus_read(4'd3);
        bus_read(4'd5);
        bus_read(4'd13);
        bus_idle();
        repeat (2) next_cycle();

        $display(">>> PASS");
        $finish;
    end

endmodule

// File: dv/tb_clock.sv
// ====================
// tb_clock
// clk_cpu and synchronous reset for the testbench
// ====================

`timescale 1ns/1ps

module tb_clock (
    output logic clk_cpu,
    output logic rst_n
);

    localparam real HALF_PERIOD = 2.0;  // 4 ns clock
    localparam int  RST_CYCLES  = 2;

    initial begin
        clk_cpu = 1'b0;
        forever #(HALF_PERIOD) clk_cpu = ~clk_cpu;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_cpu);
        @(negedge clk_cpu);
        rst_n = 1'b1;  // released on a falling edge
    end

endmodule

// File: hw/io_subsys_top.sv
// ====================
// io_subsys_top
// memory-mapped I/O block with timer, LEDs and command channels
// ====================

`timescale 1ns/1ps

module io_subsys_top #(
    parameter int TICKS_PER_MS = io_pkg::TICKS_PER_MS_DEF
) (
    input  logic                                   clk_cpu,
    input  logic                                   rst_n,
    input  io_pkg::io_req_t                        req_i,
    output logic                                   bus_ready_o,
    output logic [io_pkg::DATA_W-1:0]              rdata_o,
    output logic                                   rvalid_o,
    output logic [7:0]                             led_o,
    output logic [io_pkg::NUM_CH-1:0]              cmd_valid_o,
    output io_pkg::cmd_word_t [io_pkg::NUM_CH-1:0] cmd_data_o,
    input  logic [io_pkg::NUM_CH-1:0]              cmd_ready_i
);

    logic [io_pkg::NUM_CH-1:0]            ch_full;
    logic [io_pkg::NUM_CH-1:0]            push;
    io_pkg::cmd_word_t                    push_data;
    logic                                 rd_en;
    logic [io_pkg::ADDR_W-1:0]            rd_addr;
    logic [io_pkg::DATA_W-1:0]            ms_count;
    io_pkg::ch_stat_t [io_pkg::NUM_CH-1:0] ch_stat;

    io_bus_decode i_decode (
        .clk_cpu     (clk_cpu),
        .rst_n       (rst_n),
        .req_i       (req_i),
        .ch_full_i   (ch_full),
        .bus_ready_o (bus_ready_o),
        .push_o      (push),
        .push_data_o (push_data),
        .rd_en_o     (rd_en),
        .rd_addr_o   (rd_addr),
        .led_o       (led_o)
    );

    ms_timer #(
        .TICKS_PER_MS (TICKS_PER_MS)
    ) i_timer (
        .clk_cpu (clk_cpu),
        .rst_n   (rst_n),
        .ms_o    (ms_count)
    );

    for (genvar k = 0; k < io_pkg::NUM_CH; k++) begin : g_ch
        cmd_channel i_ch (
            .clk_cpu     (clk_cpu),
            .rst_n       (rst_n),
            .push_i      (push[k]),
            .push_data_i (push_data),
            .stat_o      (ch_stat[k]),
            .cmd_valid_o (cmd_valid_o[k]),
            .cmd_data_o  (cmd_data_o[k]),
            .cmd_ready_i (cmd_ready_i[k])
        );

        assign ch_full[k] = ch_stat[k].full;  // back-pressure source
    end

    io_status_mux i_rd_mux (
        .clk_cpu   (clk_cpu),
        .rst_n     (rst_n),
        .rd_en_i   (rd_en),
        .rd_addr_i (rd_addr),
        .ms_i      (ms_count),
        .led_i     (led_o),
        .ch_stat_i (ch_stat),
        .rdata_o   (rdata_o),
        .rvalid_o  (rvalid_o)
    );

endmodule

// File: hw/io_status_mux.sv
// ====================
// io_status_mux
// registered read-back of counter, LED, status and channel counts
// ====================

`timescale 1ns/1ps

module io_status_mux (
    input  logic                                     clk_cpu,
    input  logic                                     rst_n,
    input  logic                                     rd_en_i,
    input  logic [io_pkg::ADDR_W-1:0]                rd_addr_i,
    input  logic [io_pkg::DATA_W-1:0]                ms_i,
    input  logic [7:0]                               led_i,
    input  io_pkg::ch_stat_t [io_pkg::NUM_CH-1:0]    ch_stat_i,
    output logic [io_pkg::DATA_W-1:0]                rdata_o,
    output logic                                     rvalid_o
);

    logic [io_pkg::DATA_W-1:0] status_word;
    logic [io_pkg::DATA_W-1:0] ch_word;
    logic [io_pkg::DATA_W-1:0] rd_value;
    logic [io_pkg::ADDR_W-1:0] ch_off;

    assign ch_off = rd_addr_i - io_pkg::ADR_CH_BASE;

    always_comb begin
        status_word = '0;
        ch_word     = '0;
        for (int k = 0; k < io_pkg::NUM_CH; k++) begin
            status_word[k]     = ch_stat_i[k].nonempty;
            status_word[8 + k] = ch_stat_i[k].full;  // full flags from bit 8
            if ((rd_addr_i >= io_pkg::ADR_CH_BASE) && (ch_off == k)) begin
                ch_word = io_pkg::DATA_W'(ch_stat_i[k].count);  // zero-extended
            end
        end
    end

    // channel word is already zero outside the channel range
    always_comb begin
        case (rd_addr_i)
            io_pkg::ADR_MS:     rd_value = ms_i;
            io_pkg::ADR_LED:    rd_value = {24'd0, led_i};
            io_pkg::ADR_STATUS: rd_value = status_word;
            default:            rd_value = ch_word;
        endcase
    end

    always_ff @(posedge clk_cpu) begin
        if (rd_en_i) begin
            rdata_o <= rd_value;
        end
    end

    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            rvalid_o <= 1'b0;
        end else begin
            rvalid_o <= rd_en_i;  // one cycle after acceptance
        end
    end

endmodule

// File: hw/cmd_channel.sv
// ====================
// cmd_channel
// command word queue with a valid/ready output stream
// ====================

`timescale 1ns/1ps

module cmd_channel (
    input  logic              clk_cpu,
    input  logic              rst_n,
    input  logic              push_i,
    input  io_pkg::cmd_word_t push_data_i,
    output io_pkg::ch_stat_t  stat_o,
    output logic              cmd_valid_o,
    output io_pkg::cmd_word_t cmd_data_o,
    input  logic              cmd_ready_i
);

    io_pkg::cmd_word_t                 mem [io_pkg::CH_DEPTH];
    logic [$clog2(io_pkg::CH_DEPTH)-1:0] wr_ptr;
    logic [$clog2(io_pkg::CH_DEPTH)-1:0] rd_ptr;
    logic [io_pkg::CH_CNT_W-1:0]       count;
    logic                              full;
    logic                              do_push;
    logic                              do_pop;

    assign full    = (count == io_pkg::CH_DEPTH);
    assign do_push = push_i && !full;
    assign do_pop  = cmd_valid_o && cmd_ready_i;

    // head of queue drives the stream directly
    assign cmd_valid_o = (count != '0);
    assign cmd_data_o  = mem[rd_ptr];

    always_ff @(posedge clk_cpu) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither
            endcase
        end
    end

    assign stat_o.full     = full;
    assign stat_o.nonempty = cmd_valid_o;
    assign stat_o.count    = count;

    a_count_max: assert property (
        @(posedge clk_cpu) disable iff (!rst_n)
        count <= io_pkg::CH_DEPTH
    ) else $error("channel count %h over depth", count);

    // stalled word must hold until the sink takes it
    a_stall_stable: assert property (
        @(posedge clk_cpu) disable iff (!rst_n)
        (cmd_valid_o && !cmd_ready_i) |=> (cmd_valid_o && $stable(cmd_data_o))
    ) else $error("cmd_data_o changed while stalled, now %h", cmd_data_o);

endmodule

// File: hw/ms_timer.sv
// ====================
// ms_timer
// clk_cpu prescaler driving a free-running millisecond count
// ====================

`timescale 1ns/1ps

module ms_timer #(
    parameter int TICKS_PER_MS = io_pkg::TICKS_PER_MS_DEF
) (
    input  logic                      clk_cpu,
    input  logic                      rst_n,
    output logic [io_pkg::DATA_W-1:0] ms_o
);

    logic [$clog2(TICKS_PER_MS+1)-1:0] presc;
    logic                              wrap;

    assign wrap = (presc == TICKS_PER_MS - 1);

    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            presc <= '0;
            ms_o  <= '0;
        end else begin
            presc <= wrap ? '0 : presc + 1'b1;
            ms_o  <= ms_o + wrap;  // one step per wrap
        end
    end

    a_presc_limit: assert property (
        @(posedge clk_cpu) disable iff (!rst_n)
        presc <= TICKS_PER_MS - 1
    ) else $error("prescaler %h past limit", presc);

endmodule

// File: hw/io_bus_decode.sv
// ====================
// io_bus_decode
// bus address decode, LED register and channel back-pressure
// ====================

`timescale 1ns/1ps

module io_bus_decode (
    input  logic                          clk_cpu,
    input  logic                          rst_n,
    input  io_pkg::io_req_t               req_i,
    input  logic [io_pkg::NUM_CH-1:0]     ch_full_i,
    output logic                          bus_ready_o,
    output logic [io_pkg::NUM_CH-1:0]     push_o,
    output io_pkg::cmd_word_t             push_data_o,
    output logic                          rd_en_o,
    output logic [io_pkg::ADDR_W-1:0]     rd_addr_o,
    output logic [7:0]                    led_o
);

    logic [io_pkg::ADDR_W-1:0] ch_off;
    logic                      in_ch_range;
    logic [io_pkg::NUM_CH-1:0] ch_hit;     // one-hot target channel
    logic                      hit_full;
    logic                      accept;
    logic                      acc_wr;

    assign ch_off      = req_i.addr - io_pkg::ADR_CH_BASE;
    assign in_ch_range = (req_i.addr >= io_pkg::ADR_CH_BASE);

    always_comb begin
        for (int k = 0; k < io_pkg::NUM_CH; k++) begin
            ch_hit[k] = in_ch_range && (ch_off == k);
        end
    end

    assign hit_full = |(ch_hit & ch_full_i);

    // stall only a write that targets a full channel
    assign bus_ready_o = !(req_i.sel && req_i.we && hit_full);

    assign accept = req_i.sel && bus_ready_o;
    assign acc_wr = accept && req_i.we;

    assign push_o      = ch_hit & {io_pkg::NUM_CH{acc_wr}};
    assign push_data_o = req_i.wdata;

    assign rd_en_o   = accept && !req_i.we;  // registered in the read mux
    assign rd_addr_o = req_i.addr;

    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            led_o <= 8'd0;
        end else if (acc_wr && (req_i.addr == io_pkg::ADR_LED)) begin
            led_o <= req_i.wdata[7:0];  // low byte only
        end
    end

    // a push must never land in a channel that reports full
    a_no_push_full: assert property (
        @(posedge clk_cpu) disable iff (!rst_n)
        (push_o & ch_full_i) == '0
    ) else $error("push_o=%h into full channel, ch_full_i=%h", push_o, ch_full_i);

endmodule

// File: hw/io_pkg.sv
// ====================
// io_pkg
// address map, sizes and shared structs of the I/O subsystem
// ====================

package io_pkg;

    localparam int NUM_CH           = 4;      // command channels
    localparam int CH_DEPTH         = 8;      // words per channel queue
    localparam int CH_CNT_W         = 4;      // fill count, holds 0..CH_DEPTH
    localparam int ADDR_W           = 4;      // word address
    localparam int DATA_W           = 32;
    localparam int TICKS_PER_MS_DEF = 25000;  // 25 MHz clk_cpu

    // word address map
    localparam logic [ADDR_W-1:0] ADR_MS      = 4'd0;
    localparam logic [ADDR_W-1:0] ADR_LED     = 4'd1;
    localparam logic [ADDR_W-1:0] ADR_STATUS  = 4'd2;
    localparam logic [ADDR_W-1:0] ADR_CH_BASE = 4'd8;  // channel k at 8+k

    // one request on the CPU register bus
    typedef struct packed {
        logic              sel;
        logic              we;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } io_req_t;

    typedef logic [DATA_W-1:0] cmd_word_t;

    // channel state for read-back
    typedef struct packed {
        logic                full;
        logic                nonempty;
        logic [CH_CNT_W-1:0] count;
    } ch_stat_t;

endpackage
